/* hw/eth_audio_pkg.sv */
package eth_audio_pkg;

    // ~~~~~~~~~~ Audio and addressing ~~~~~~~~~~
    localparam int          SAMPLE_WIDTH    = 16;
    localparam logic [47:0] LOCAL_MAC       = 48'h02_00_00_00_00_00;
    localparam logic [47:0] BCAST_MAC       = 48'hFF_FF_FF_FF_FF_FF;
    localparam logic [15:0] AUDIO_ETHERTYPE = 16'h88B5;

    // ~~~~~~~~~~ Frame layout ~~~~~~~~~~~~~~~~~~~
    localparam logic [7:0]  PREAMBLE_BYTE     = 8'h55;
    localparam logic [7:0]  SFD_BYTE          = 8'hD5;
    localparam int          PREAMBLE_LEN      = 7;
    localparam int          HDR_LEN           = 14;   // Destination, source, type.
    localparam int          SAMPLES_PER_FRAME = 16;
    localparam int          PAYLOAD_START     = PREAMBLE_LEN + 1 + HDR_LEN;
    localparam int          FRAME_BYTES       = PAYLOAD_START + 2 * SAMPLES_PER_FRAME;

    // ~~~~~~~~~~ Timing ~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int          IFG_CYCLES     = 12;      // Idle byte times between frames.
    localparam int          RST_SYNC_DEPTH = 4;

    // ~~~~~~~~~~ State encodings ~~~~~~~~~~~~~~~~
    localparam logic [1:0]  RX_IDLE = 2'd0;
    localparam logic [1:0]  RX_HUNT = 2'd1;           // Looking for preamble and SFD.
    localparam logic [1:0]  RX_DATA = 2'd2;
    localparam logic [1:0]  RX_DROP = 2'd3;           // Error seen, wait for dv low.

    localparam logic [1:0]  GEN_IDLE  = 2'd0;
    localparam logic [1:0]  GEN_FRAME = 2'd1;
    localparam logic [1:0]  GEN_GAP   = 2'd2;

endpackage

/* hw/sync_reset.sv */
`timescale 1ns/1ps

module sync_reset import eth_audio_pkg::*; (
    input  logic clk_int,
    input  logic rst,
    output logic rst_int
);

    logic [RST_SYNC_DEPTH-1:0] rst_sr;

    // Forced high by rst, drains one stage per cycle.
    always_ff @(posedge clk_int) begin
        if (rst) begin
            rst_sr <= '1;
        end else begin
            rst_sr <= {rst_sr[RST_SYNC_DEPTH-2:0], 1'b0};
        end
    end

    assign rst_int = rst_sr[RST_SYNC_DEPTH-1];

endmodule

/* hw/mii_rx.sv */
`timescale 1ns/1ps

module mii_rx import eth_audio_pkg::*; (
    input  logic       clk_int,
    input  logic       rst_int,
    input  logic [3:0] phy_rxd,
    input  logic       phy_rx_dv,
    input  logic       phy_rx_er,
    output logic [7:0] rx_byte,
    output logic       rx_byte_valid,
    output logic       rx_frame_start,
    output logic       rx_frame_end,
    output logic       rx_frame_abort
);

    logic [1:0] state;
    logic [3:0] low_nib;     // Previous nibble.
    logic       nib_phase;   // High nibble expected next.
    logic       pre_seen;
    logic       first_byte;
    logic [7:0] cur_byte;

    assign cur_byte = {phy_rxd, low_nib};

    // ~~~~~~~~~~ Framing FSM ~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            state          <= RX_IDLE;
            nib_phase      <= 1'b0;
            pre_seen       <= 1'b0;
            first_byte     <= 1'b0;
            rx_byte_valid  <= 1'b0;
            rx_frame_start <= 1'b0;
            rx_frame_end   <= 1'b0;
            rx_frame_abort <= 1'b0;
        end else begin
            rx_byte_valid  <= 1'b0;
            rx_frame_start <= 1'b0;
            rx_frame_end   <= 1'b0;
            rx_frame_abort <= 1'b0;
            case (state)
                RX_IDLE: begin
                    pre_seen <= 1'b0;
                    if (phy_rx_dv) begin
                        state <= RX_HUNT;
                    end
                end
                RX_HUNT: begin
                    if (!phy_rx_dv) begin
                        state <= RX_IDLE;
                    end else if (phy_rx_er) begin
                        pre_seen <= 1'b0;
                    end else if (pre_seen && cur_byte == SFD_BYTE) begin
                        state      <= RX_DATA;   // Delimiter sets byte alignment.
                        nib_phase  <= 1'b0;
                        first_byte <= 1'b1;
                    end else if (cur_byte == PREAMBLE_BYTE) begin
                        pre_seen <= 1'b1;
                    end
                end
                RX_DATA: begin
                    if (!phy_rx_dv) begin
                        rx_frame_end <= 1'b1;
                        state        <= RX_IDLE;
                    end else if (phy_rx_er) begin
                        rx_frame_abort <= 1'b1;
                        state          <= RX_DROP;
                    end else if (nib_phase) begin
                        rx_byte_valid  <= 1'b1;
                        rx_frame_start <= first_byte;
                        first_byte     <= 1'b0;
                        nib_phase      <= 1'b0;
                    end else begin
                        nib_phase <= 1'b1;
                    end
                end
                default: begin
                    if (!phy_rx_dv) begin
                        rx_frame_end <= 1'b1;
                        state        <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // ~~~~~~~~~~ Byte assembly ~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_int) begin
        low_nib <= phy_rxd;
        if (state == RX_DATA && nib_phase) begin
            rx_byte <= cur_byte;   // High nibble straight from the pins.
        end
    end

endmodule

/* hw/audio_frame_parser.sv */
`timescale 1ns/1ps

module audio_frame_parser import eth_audio_pkg::*; (
    input  logic                    clk_int,
    input  logic                    rst_int,
    input  logic [7:0]              rx_byte,
    input  logic                    rx_byte_valid,
    input  logic                    rx_frame_start,
    input  logic                    rx_frame_end,
    input  logic                    rx_frame_abort,
    output logic [SAMPLE_WIDTH-1:0] sample_data,
    output logic                    sample_valid,
    output logic                    frame_ok
);

    logic [3:0]  hdr_cnt;
    logic [3:0]  byte_idx;
    logic [39:0] dst_sr;      // First five destination bytes.
    logic [7:0]  type_hi;
    logic [7:0]  hi_byte;
    logic        dst_ok;
    logic        accepted;
    logic        aborted;
    logic        have_hi;
    logic        in_payload;

    assign byte_idx   = rx_frame_start ? 4'd0 : hdr_cnt;
    assign in_payload = (byte_idx == 4'(HDR_LEN));

    // ~~~~~~~~~~ Header and payload data ~~~~~~~
    always_ff @(posedge clk_int) begin
        if (rx_byte_valid) begin
            if (byte_idx < 4'd5) begin
                dst_sr <= {dst_sr[31:0], rx_byte};
            end
            if (byte_idx == 4'(HDR_LEN - 2)) begin
                type_hi <= rx_byte;
            end
            if (in_payload && !have_hi) begin
                hi_byte <= rx_byte;
            end
            if (in_payload && have_hi) begin
                sample_data <= {hi_byte, rx_byte};   // First byte is high.
            end
        end
    end

    // ~~~~~~~~~~ Filter and sample control ~~~~~
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            hdr_cnt      <= 4'd0;
            dst_ok       <= 1'b0;
            accepted     <= 1'b0;
            aborted      <= 1'b0;
            have_hi      <= 1'b0;
            sample_valid <= 1'b0;
            frame_ok     <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            frame_ok     <= 1'b0;
            if (rx_frame_start) begin
                accepted <= 1'b0;
                aborted  <= 1'b0;
                have_hi  <= 1'b0;   // Drops a trailing odd byte.
            end
            if (rx_byte_valid) begin
                if (!in_payload) begin
                    hdr_cnt <= byte_idx + 4'd1;
                end
                if (byte_idx == 4'd5) begin
                    dst_ok <= ({dst_sr, rx_byte} == LOCAL_MAC) ||
                              ({dst_sr, rx_byte} == BCAST_MAC);
                end
                if (byte_idx == 4'(HDR_LEN - 1)) begin
                    accepted <= dst_ok && ({type_hi, rx_byte} == AUDIO_ETHERTYPE);
                end
                if (in_payload && accepted && !aborted) begin
                    have_hi      <= !have_hi;
                    sample_valid <= have_hi;
                end
            end
            if (rx_frame_abort) begin
                aborted <= 1'b1;
            end
            if (rx_frame_end) begin
                frame_ok <= accepted && !aborted;
                accepted <= 1'b0;
            end
        end
    end

endmodule

/* hw/screamer_gen.sv */
`timescale 1ns/1ps

module screamer_gen import eth_audio_pkg::*; (
    input  logic       clk_int,
    input  logic       rst_int,
    input  logic       screamer_enable,
    output logic [7:0] tx_byte,
    output logic       tx_byte_valid,
    output logic       tx_last
);

    logic [1:0]              state;
    logic                    phase;       // Byte slot when low.
    logic [5:0]              byte_cnt;    // Frame byte or gap byte time.
    logic                    lo_half;
    logic [SAMPLE_WIDTH-1:0] sample_cnt;  // Ramp runs across frames.
    logic [8*HDR_LEN-1:0]    hdr_sr;
    logic                    byte_slot;
    logic                    in_payload;

    assign byte_slot  = (state == GEN_FRAME) && !phase;
    assign in_payload = (byte_cnt >= 6'(PAYLOAD_START));

    // ~~~~~~~~~~ Sequencer ~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            state         <= GEN_IDLE;
            phase         <= 1'b0;
            byte_cnt      <= 6'd0;
            lo_half       <= 1'b0;
            sample_cnt    <= '0;
            tx_byte_valid <= 1'b0;
            tx_last       <= 1'b0;
        end else begin
            tx_byte_valid <= 1'b0;
            tx_last       <= 1'b0;
            case (state)
                GEN_IDLE: begin
                    if (screamer_enable) begin   // Only checked between frames.
                        state    <= GEN_FRAME;
                        phase    <= 1'b1;
                        byte_cnt <= 6'd0;
                        lo_half  <= 1'b0;
                    end
                end
                GEN_FRAME: begin
                    phase <= ~phase;
                    if (!phase) begin
                        tx_byte_valid <= 1'b1;
                        if (in_payload) begin
                            lo_half <= ~lo_half;
                            if (lo_half) begin
                                sample_cnt <= sample_cnt + 1'b1;
                            end
                        end
                        if (byte_cnt == 6'(FRAME_BYTES - 1)) begin
                            tx_last  <= 1'b1;
                            state    <= GEN_GAP;
                            byte_cnt <= 6'd0;
                        end else begin
                            byte_cnt <= byte_cnt + 6'd1;
                        end
                    end
                end
                default: begin
                    phase <= ~phase;
                    if (phase) begin
                        if (byte_cnt == 6'(IFG_CYCLES - 1)) begin
                            state <= GEN_IDLE;
                        end else begin
                            byte_cnt <= byte_cnt + 6'd1;
                        end
                    end
                end
            endcase
        end
    end

    // ~~~~~~~~~~ Byte mux ~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_int) begin
        if (state == GEN_IDLE) begin
            hdr_sr <= {BCAST_MAC, LOCAL_MAC, AUDIO_ETHERTYPE};
        end
        if (byte_slot) begin
            if (byte_cnt < 6'(PREAMBLE_LEN)) begin
                tx_byte <= PREAMBLE_BYTE;
            end else if (byte_cnt == 6'(PREAMBLE_LEN)) begin
                tx_byte <= SFD_BYTE;
            end else if (!in_payload) begin
                tx_byte <= hdr_sr[8*HDR_LEN-1 -: 8];
                hdr_sr  <= hdr_sr << 8;
            end else if (!lo_half) begin
                tx_byte <= sample_cnt[SAMPLE_WIDTH-1 -: 8];   // High byte first.
            end else begin
                tx_byte <= sample_cnt[7:0];
            end
        end
    end

endmodule

/* hw/mii_tx.sv */
`timescale 1ns/1ps

module mii_tx (
    input  logic       clk_int,
    input  logic       rst_int,
    input  logic [7:0] tx_byte,
    input  logic       tx_byte_valid,
    input  logic       tx_last,
    output logic [3:0] phy_txd,
    output logic       phy_tx_en
);

    logic       high_next;   // High nibble goes out next cycle.
    logic       last_held;
    logic [3:0] high_nib;
    logic       take;

    assign take = tx_byte_valid && !high_next;

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            phy_tx_en <= 1'b0;
            high_next <= 1'b0;
            last_held <= 1'b0;
        end else if (take) begin
            phy_tx_en <= 1'b1;
            high_next <= 1'b1;
            last_held <= tx_last;
        end else if (high_next) begin
            high_next <= 1'b0;
        end else if (last_held) begin
            phy_tx_en <= 1'b0;   // Frame done.
            last_held <= 1'b0;
        end
    end

    always_ff @(posedge clk_int) begin
        if (take) begin
            phy_txd  <= tx_byte[3:0];
            high_nib <= tx_byte[7:4];
        end else if (high_next) begin
            phy_txd <= high_nib;
        end
    end

endmodule

/* hw/eth_audio_top.sv */
`timescale 1ns/1ps

module eth_audio_top import eth_audio_pkg::*; (
    input  logic                    clk_int,
    input  logic                    rst,
    input  logic [3:0]              sw,
    input  logic [3:0]              btn,
    output logic                    led0_r,
    output logic                    led1_g,
    output logic                    led4,
    output logic                    led5,
    output logic                    led6,
    output logic                    led7,
    input  logic [3:0]              phy_rxd,
    input  logic                    phy_rx_dv,
    input  logic                    phy_rx_er,
    output logic [3:0]              phy_txd,
    output logic                    phy_tx_en,
    output logic                    phy_reset_n,
    output logic [SAMPLE_WIDTH-1:0] dac_sample,
    output logic                    dac_valid
);

    logic                    rst_int;
    logic [7:0]              rx_byte;
    logic                    rx_byte_valid;
    logic                    rx_frame_start;
    logic                    rx_frame_end;
    logic                    rx_frame_abort;
    logic [SAMPLE_WIDTH-1:0] sample_data;
    logic                    sample_valid;
    logic                    frame_ok;
    logic [7:0]              tx_byte;
    logic                    tx_byte_valid;
    logic                    tx_last;

    sync_reset i_sync_reset (
        .clk_int (clk_int),
        .rst     (rst),
        .rst_int (rst_int)
    );

    assign phy_reset_n = ~rst_int;

    mii_rx i_mii_rx (
        .clk_int        (clk_int),
        .rst_int        (rst_int),
        .phy_rxd        (phy_rxd),
        .phy_rx_dv      (phy_rx_dv),
        .phy_rx_er      (phy_rx_er),
        .rx_byte        (rx_byte),
        .rx_byte_valid  (rx_byte_valid),
        .rx_frame_start (rx_frame_start),
        .rx_frame_end   (rx_frame_end),
        .rx_frame_abort (rx_frame_abort)
    );

    audio_frame_parser i_audio_frame_parser (
        .clk_int        (clk_int),
        .rst_int        (rst_int),
        .rx_byte        (rx_byte),
        .rx_byte_valid  (rx_byte_valid),
        .rx_frame_start (rx_frame_start),
        .rx_frame_end   (rx_frame_end),
        .rx_frame_abort (rx_frame_abort),
        .sample_data    (sample_data),
        .sample_valid   (sample_valid),
        .frame_ok       (frame_ok)
    );

    screamer_gen i_screamer_gen (
        .clk_int         (clk_int),
        .rst_int         (rst_int),
        .screamer_enable (btn[0]),
        .tx_byte         (tx_byte),
        .tx_byte_valid   (tx_byte_valid),
        .tx_last         (tx_last)
    );

    mii_tx i_mii_tx (
        .clk_int       (clk_int),
        .rst_int       (rst_int),
        .tx_byte       (tx_byte),
        .tx_byte_valid (tx_byte_valid),
        .tx_last       (tx_last),
        .phy_txd       (phy_txd),
        .phy_tx_en     (phy_tx_en)
    );

    // ~~~~~~~~~~ LEDs and DAC port ~~~~~~~~~~~~~
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            {led7, led6, led5, led4} <= 4'd0;
            led0_r    <= 1'b0;
            led1_g    <= 1'b0;
            dac_valid <= 1'b0;
        end else begin
            {led7, led6, led5, led4} <= sw;
            led0_r    <= btn[0];
            dac_valid <= sample_valid;
            if (frame_ok) begin
                led1_g <= ~led1_g;   // One toggle per accepted frame.
            end
        end
    end

    always_ff @(posedge clk_int) begin
        if (sample_valid) begin
            dac_sample <= sample_data;
        end
    end

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk_int
);

    localparam real HALF_PERIOD = 2.0;   // 4 ns period.

    initial begin
        clk_int = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_int = ~clk_int;
        end
    end

endmodule

/* tb/tb_eth_audio.sv */
`timescale 1ns/1ps

module tb_eth_audio import eth_audio_pkg::*; ();

    localparam int RX_CYCLES = 6 * (2 * (PAYLOAD_START + 2 * 24 + 1) + 20);
    localparam int TX_CYCLES = 5 * (2 * FRAME_BYTES + 2 * IFG_CYCLES + 8);
    localparam int LIMIT     = RX_CYCLES + TX_CYCLES + 1000;   // Cycles.
    localparam logic [47:0] OTHER_MAC = 48'h02_11_22_33_44_55;

    logic                    clk_int;
    logic                    rst;
    logic [3:0]              sw;
    logic                    btn0;
    logic [2:0]              btn_hi;
    logic [3:0]              btn;
    logic                    led0_r, led1_g, led4, led5, led6, led7;
    logic [3:0]              phy_rxd;
    logic                    phy_rx_dv;
    logic                    phy_rx_er;
    logic [3:0]              phy_txd;
    logic                    phy_tx_en;
    logic                    phy_reset_n;
    logic [SAMPLE_WIDTH-1:0] dac_sample;
    logic                    dac_valid;

    logic [3:0] drv_rxd;
    logic       drv_dv;
    logic       drv_er;
    logic       loopback;

    int          seed = 32'h7b7d;
    int          cyc = 0;
    int          edges = 0;
    int          rel_cnt = 0;      // Cycles since rst fell.
    int          err_value = 0;
    int          err_other = 0;
    int          toggles = 0;
    int          exp_toggles = 0;
    int          tx_frames = 0;
    int          rises_after = 0;
    int          ramp_seen = 0;
    logic [15:0] ramp_next = 16'd0;
    bit          released = 1'b0;
    logic [3:0]  prev_sw = 4'd0;
    logic        prev_btn0 = 1'b0;
    logic        prev_rstn = 1'b0;
    logic        prev_led1 = 1'b0;
    logic        prev_tx_en = 1'b0;
    logic [15:0] exp_data[$];
    int          exp_due[$];

    assign btn       = {btn_hi, btn0};
    assign phy_rxd   = loopback ? phy_txd : drv_rxd;   // Receive source mux.
    assign phy_rx_dv = loopback ? phy_tx_en : drv_dv;
    assign phy_rx_er = loopback ? 1'b0 : drv_er;

    clk_gen i_clk_gen (.clk_int(clk_int));

    eth_audio_top i_eth_audio_top (
        .clk_int     (clk_int),
        .rst         (rst),
        .sw          (sw),
        .btn         (btn),
        .led0_r      (led0_r),
        .led1_g      (led1_g),
        .led4        (led4),
        .led5        (led5),
        .led6        (led6),
        .led7        (led7),
        .phy_rxd     (phy_rxd),
        .phy_rx_dv   (phy_rx_dv),
        .phy_rx_er   (phy_rx_er),
        .phy_txd     (phy_txd),
        .phy_tx_en   (phy_tx_en),
        .phy_reset_n (phy_reset_n),
        .dac_sample  (dac_sample),
        .dac_valid   (dac_valid)
    );

    // ~~~~~~~~~~ History and counters ~~~~~~~~~~
    always @(posedge clk_int) begin
        cyc        <= cyc + 1;
        edges      <= edges + 1;
        rel_cnt    <= rst ? 0 : (rel_cnt < 100 ? rel_cnt + 1 : rel_cnt);
        prev_sw    <= sw;
        prev_btn0  <= btn0;
        prev_rstn  <= phy_reset_n;
        prev_led1  <= led1_g;
        prev_tx_en <= phy_tx_en;
        if (edges >= 2 && led1_g != prev_led1) begin
            toggles <= toggles + 1;
        end
        if (edges >= 2 && phy_tx_en && !prev_tx_en) begin
            tx_frames <= tx_frames + 1;
            if (released) begin
                rises_after <= rises_after + 1;
            end
        end
    end

    // ~~~~~~~~~~ Assertions ~~~~~~~~~~~~~~~~~~~~
    a_phy_reset: assert property (@(posedge clk_int) disable iff (edges < 2)
        phy_reset_n == (rel_cnt >= RST_SYNC_DEPTH))
    else begin
        err_value++;
        $display("error %0t: phy_reset_n is %b after %0d cycles", $time, phy_reset_n, rel_cnt);
    end

    a_quiet: assert property (@(posedge clk_int) disable iff (edges < 2)
        !prev_rstn |-> (!phy_tx_en && !dac_valid && !led1_g))
    else begin
        err_value++;
        $display("error %0t: outputs active during reset", $time);
    end

    a_leds: assert property (@(posedge clk_int) disable iff (edges < 2)
        {led7, led6, led5, led4} == (prev_rstn ? prev_sw : 4'd0) &&
        led0_r == (prev_rstn ? prev_btn0 : 1'b0))
    else begin
        err_value++;
        $display("error %0t: leds %b%b%b%b r%b, expected %b r%b", $time,
                 led7, led6, led5, led4, led0_r, prev_sw, prev_btn0);
    end

    // Each finished loopback frame adds a full set of samples.
    a_frame_smp: assert property (@(posedge clk_int) disable iff (edges < 2)
        (loopback && phy_tx_en && !prev_tx_en) |->
        ramp_seen == tx_frames * SAMPLES_PER_FRAME)
    else begin
        err_value++;
        $display("error %0t: %0d ramp samples after %0d frames", $time,
                 ramp_seen, tx_frames);
    end

    // Scoreboard for received samples.
    always @(posedge clk_int) begin
        if (dac_valid) begin
            if (loopback) begin
                a_ramp: assert (dac_sample == ramp_next) else begin
                    err_value++;
                    $display("error %0t: ramp sample %h, expected %h", $time,
                             dac_sample, ramp_next);
                end
                ramp_next <= ramp_next + 16'd1;
                ramp_seen <= ramp_seen + 1;
            end else if (exp_data.size() == 0) begin
                err_other++;
                $display("Sample %h arrived at %0t when none was expected", dac_sample, $time);
            end else begin
                a_sample: assert (dac_sample == exp_data[0] && cyc == exp_due[0]) else begin
                    err_value++;
                    $display("error %0t: sample %h at cycle %0d, expected %h at %0d", $time,
                             dac_sample, cyc, exp_data[0], exp_due[0]);
                end
                void'(exp_data.pop_front());
                void'(exp_due.pop_front());
            end
        end
    end

    // ~~~~~~~~~~ Frame model ~~~~~~~~~~~~~~~~~~~
    // err_byte is the payload byte whose low nibble carries rx_er, or -1.
    task automatic send_frame(input logic [47:0] dst, input logic [15:0] etype,
                              input int nsamp, input bit odd_tail, input int err_byte);
        logic [7:0]  bytes[$];
        logic [15:0] smp[$];
        bit          pass;
        int          p;
        pass = (dst == LOCAL_MAC || dst == BCAST_MAC) && etype == AUDIO_ETHERTYPE;
        for (int i = 0; i < PREAMBLE_LEN; i++) begin
            bytes.push_back(PREAMBLE_BYTE);
        end
        bytes.push_back(SFD_BYTE);
        for (int i = 0; i < 6; i++) begin
            bytes.push_back(dst[47 - 8 * i -: 8]);
        end
        for (int i = 0; i < 6; i++) begin
            bytes.push_back(OTHER_MAC[47 - 8 * i -: 8]);
        end
        bytes.push_back(etype[15:8]);
        bytes.push_back(etype[7:0]);
        for (int s = 0; s < nsamp; s++) begin
            smp.push_back(16'($random(seed)));
            bytes.push_back(smp[s][15:8]);
            bytes.push_back(smp[s][7:0]);
        end
        if (odd_tail) begin
            bytes.push_back(8'($random(seed)));
        end
        for (int idx = 0; idx < bytes.size(); idx++) begin
            for (int nib = 0; nib < 2; nib++) begin
                @(posedge clk_int);
                #0.5;
                drv_dv  = 1'b1;
                drv_rxd = nib ? bytes[idx][7:4] : bytes[idx][3:0];
                drv_er  = (err_byte >= 0 && idx == PAYLOAD_START + err_byte && nib == 0);
                p = idx - PAYLOAD_START;
                if (nib == 1 && pass && p >= 0 && p % 2 == 1 && p / 2 < nsamp &&
                    (err_byte < 0 || p < err_byte)) begin
                    exp_data.push_back(smp[p / 2]);
                    exp_due.push_back(cyc + 3);   // Pins, rx byte, parser, DAC reg.
                end
            end
        end
        @(posedge clk_int);
        #0.5;
        drv_dv = 1'b0;
        drv_er = 1'b0;
        if (pass && err_byte < 0) begin
            exp_toggles++;
        end
        repeat (16) @(posedge clk_int);
    endtask

    // ~~~~~~~~~~ Stimulus ~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        forever begin
            @(posedge clk_int);
            #0.5;
            sw     = 4'($random(seed));
            btn_hi = 3'($random(seed));
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk_int);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        sw       = 4'd0;
        btn0     = 1'b0;
        btn_hi   = 3'd0;
        drv_rxd  = 4'd0;
        drv_dv   = 1'b0;
        drv_er   = 1'b0;
        loopback = 1'b0;
        repeat (4) @(posedge clk_int);
        #0.5;
        rst = 1'b0;
        repeat (12) @(posedge clk_int);

        send_frame(LOCAL_MAC, AUDIO_ETHERTYPE, 8, 1'b0, -1);
        send_frame(BCAST_MAC, AUDIO_ETHERTYPE, 5, 1'b1, -1);
        send_frame(OTHER_MAC, AUDIO_ETHERTYPE, 6, 1'b0, -1);
        send_frame(LOCAL_MAC, 16'h0800, 6, 1'b0, -1);
        send_frame(LOCAL_MAC, AUDIO_ETHERTYPE, 10, 1'b0, 6);
        send_frame(LOCAL_MAC, AUDIO_ETHERTYPE, 24, 1'b0, -1);

        // Screamer loopback.
        @(posedge clk_int);
        #0.5;
        loopback = 1'b1;
        btn0     = 1'b1;
        wait (tx_frames >= 3);
        @(posedge clk_int);
        #0.5;
        btn0     = 1'b0;
        released = 1'b1;
        wait (!phy_tx_en);
        repeat (2 * FRAME_BYTES + 2 * IFG_CYCLES + 40) @(posedge clk_int);
        exp_toggles += tx_frames;

        a_queue_empty: assert (exp_data.size() == 0) else begin
            err_other++;
            $display("%0d expected samples never arrived", exp_data.size());
        end
        a_toggles: assert (toggles == exp_toggles) else begin
            err_value++;
            $display("error %0t: led1_g toggled %0d times, expected %0d", $time,
                     toggles, exp_toggles);
        end
        a_frame_len: assert (ramp_seen == tx_frames * SAMPLES_PER_FRAME) else begin
            err_value++;
            $display("error %0t: %0d ramp samples over %0d frames", $time,
                     ramp_seen, tx_frames);
        end
        a_tx_stopped: assert (!phy_tx_en && rises_after == 0) else begin
            err_other++;
            $display("Transmitter kept sending after the button was released");
        end

        $display("Errors: %0d value, %0d other", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* all.f */
hw/eth_audio_pkg.sv
hw/sync_reset.sv
hw/mii_rx.sv
hw/audio_frame_parser.sv
hw/screamer_gen.sv
hw/mii_tx.sv
hw/eth_audio_top.sv
tb/clk_gen.sv
tb/tb_eth_audio.sv

/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -f all.f --top-module tb_eth_audio \
		-Mdir obj_dir -o Vtb_eth_audio

run: compile
	./obj_dir/Vtb_eth_audio > $(LOG) 2>&1; true
	cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
